/* rv_ctrl_settings.svh */
`ifndef RV_CTRL_SETTINGS_SVH
`define RV_CTRL_SETTINGS_SVH

`define RV_REG_AW     5          // register index width
`define RV_OPC_W      7
`define RV_FUNCT3_W   3
`define RV_FUNCT7_W   7

`define RV_F7_BASE    7'b0000000 // add, srl and friends
`define RV_F7_ALT     7'b0100000 // sub / sra

`define RV_OPC_R      7'b0110011
`define RV_OPC_I      7'b0010011
`define RV_OPC_B      7'b1100011
`define RV_OPC_LOAD   7'b0000011
`define RV_OPC_STORE  7'b0100011
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_AUIPC  7'b0010111
`define RV_OPC_JAL    7'b1101111
`define RV_OPC_JALR   7'b1100111

`endif

/* rv_ctrl_pkg.sv */
`default_nettype none

`include "rv_ctrl_settings.svh"

package rv_ctrl_pkg;

    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    // encodings follow the datapath ALU
    typedef enum logic [4:0] {
        ALU_AND = 5'd0,
        ALU_OR  = 5'd1,
        ALU_ADD = 5'd2,
        ALU_SUB = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRL = 5'd5,
        ALU_SRA = 5'd6,
        ALU_XOR = 5'd7,
        ALU_LUI = 5'd8
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_REGFILE  = 2'd0,
        FWD_EXE_ALU  = 2'd1, // alu result of instr in exe
        FWD_MEM_ALU  = 2'd2, // alu result of instr in mem
        FWD_MEM_LOAD = 2'd3  // load data in mem
    } fwd_sel_t;

    typedef enum logic [1:0] {
        PC_PC4    = 2'd0,
        PC_BRANCH = 2'd1,
        PC_JAL    = 2'd2
    } pc_sel_t;

    // jalr target goes through the same mux leg as a taken branch
    localparam pc_sel_t PC_JALR = PC_BRANCH;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_JAL  = 3'd5,
        BR_JALR = 3'd6
    } branch_kind_t;

    typedef struct packed {
        alu_op_t aluc;
        logic    wreg;
        logic    wmem;
        logic    mem2reg;
        logic    aluimm;
        logic    jal;
        logic    jalr;
        logic    signext;
        logic    auipc;
        logic    ls_b;           // byte access
        logic    ls_h;           // halfword access
        logic    load_signext;
        logic    slt_instr;
        logic    compare_signed;
        logic    compare_imm;
    } ctrl_t;

endpackage

`default_nettype wire

/* rv_ctrl_if.sv */
`default_nettype none

// write-back info of the two stages ahead of decode
interface stage_wb_if;
    logic                  exe_wreg;
    logic                  exe_mem2reg;
    rv_ctrl_pkg::reg_addr_t exe_rd;
    logic                  mem_wreg;
    logic                  mem_mem2reg;
    rv_ctrl_pkg::reg_addr_t mem_rd;

    modport consumer (
        input exe_wreg, exe_mem2reg, exe_rd,
        input mem_wreg, mem_mem2reg, mem_rd
    );
endinterface

// source operands of the instr in decode
interface operand_use_if;
    rv_ctrl_pkg::reg_addr_t rs1;
    rv_ctrl_pkg::reg_addr_t rs2;
    logic                  use_rs1;
    logic                  use_rs2;

    modport producer (
        output use_rs1, use_rs2 // rs1/rs2 come straight from the instr word
    );

    modport consumer (
        input rs1, rs2, use_rs1, use_rs2
    );
endinterface

`default_nettype wire

/* instr_decoder.sv */
`default_nettype none

`include "rv_ctrl_settings.svh"

module instr_decoder (
    input  logic [`RV_OPC_W-1:0]    i_opcode,
    input  logic [`RV_FUNCT3_W-1:0] i_funct3,
    input  logic [`RV_FUNCT7_W-1:0] i_funct7,
    output rv_ctrl_pkg::ctrl_t        o_ctrl,
    output rv_ctrl_pkg::branch_kind_t o_branch,
    operand_use_if.producer           ops
);

    always_comb
    begin
        o_ctrl      = '0;                    // unknown opcode: no writes, no flags
        o_ctrl.aluc = rv_ctrl_pkg::ALU_ADD;
        o_branch    = rv_ctrl_pkg::BR_NONE;
        ops.use_rs1 = 1'b0;
        ops.use_rs2 = 1'b0;

        case (i_opcode)
            `RV_OPC_R:
            begin
                o_ctrl.wreg    = 1'b1;
                o_ctrl.signext = 1'b1;
                ops.use_rs1    = 1'b1;
                ops.use_rs2    = 1'b1;
                if (i_funct7 == `RV_F7_BASE)
                begin
                    case (i_funct3)
                        3'b001: o_ctrl.aluc = rv_ctrl_pkg::ALU_SLL;
                        3'b010, 3'b011:                    // slt, sltu
                        begin
                            o_ctrl.slt_instr      = 1'b1;
                            o_ctrl.compare_signed = ~i_funct3[0];
                        end
                        3'b100: o_ctrl.aluc = rv_ctrl_pkg::ALU_XOR;
                        3'b101: o_ctrl.aluc = rv_ctrl_pkg::ALU_SRL;
                        3'b110: o_ctrl.aluc = rv_ctrl_pkg::ALU_OR;
                        3'b111: o_ctrl.aluc = rv_ctrl_pkg::ALU_AND;
                        default: o_ctrl.aluc = rv_ctrl_pkg::ALU_ADD;
                    endcase
                end
                else if (i_funct7 == `RV_F7_ALT)
                begin
                    case (i_funct3)
                        3'b000: o_ctrl.aluc = rv_ctrl_pkg::ALU_SUB;
                        3'b101: o_ctrl.aluc = rv_ctrl_pkg::ALU_SRA;
                        default: o_ctrl.aluc = rv_ctrl_pkg::ALU_ADD;
                    endcase
                end
            end

            `RV_OPC_I:
            begin
                o_ctrl.wreg    = 1'b1;
                o_ctrl.aluimm  = 1'b1;
                o_ctrl.signext = 1'b1;
                ops.use_rs1    = 1'b1;
                case (i_funct3)
                    3'b001:                                // slli, shamt unsigned
                    begin
                        o_ctrl.aluc    = rv_ctrl_pkg::ALU_SLL;
                        o_ctrl.signext = 1'b0;
                    end
                    3'b010, 3'b011:                        // slti, sltiu
                    begin
                        o_ctrl.slt_instr      = 1'b1;
                        o_ctrl.compare_imm    = 1'b1;
                        o_ctrl.compare_signed = ~i_funct3[0];
                    end
                    3'b100: o_ctrl.aluc = rv_ctrl_pkg::ALU_XOR;
                    3'b101:
                    begin
                        o_ctrl.signext = 1'b0;
                        if (i_funct7 == `RV_F7_BASE)
                            o_ctrl.aluc = rv_ctrl_pkg::ALU_SRL;
                        else if (i_funct7 == `RV_F7_ALT)
                            o_ctrl.aluc = rv_ctrl_pkg::ALU_SRA;
                    end
                    3'b110: o_ctrl.aluc = rv_ctrl_pkg::ALU_OR;
                    3'b111: o_ctrl.aluc = rv_ctrl_pkg::ALU_AND;
                    default: o_ctrl.aluc = rv_ctrl_pkg::ALU_ADD;
                endcase
            end

            `RV_OPC_B:
            begin
                o_ctrl.signext        = 1'b1;
                o_ctrl.compare_signed = ~i_funct3[1]; // bltu/bgeu have funct3[1] set
                ops.use_rs1           = 1'b1;
                ops.use_rs2           = 1'b1;
                case (i_funct3)
                    3'b000: o_branch = rv_ctrl_pkg::BR_EQ;
                    3'b001: o_branch = rv_ctrl_pkg::BR_NE;
                    3'b100, 3'b110: o_branch = rv_ctrl_pkg::BR_LT;
                    3'b101, 3'b111: o_branch = rv_ctrl_pkg::BR_GE;
                    default: o_branch = rv_ctrl_pkg::BR_NONE;
                endcase
            end

            `RV_OPC_LOAD:
            begin
                o_ctrl.wreg    = 1'b1;
                o_ctrl.mem2reg = 1'b1;
                o_ctrl.aluimm  = 1'b1;
                o_ctrl.signext = 1'b1;
                ops.use_rs1    = 1'b1;
                o_ctrl.ls_b    = (i_funct3 == 3'b000) || (i_funct3 == 3'b100);
                o_ctrl.ls_h    = (i_funct3 == 3'b001) || (i_funct3 == 3'b101);
                o_ctrl.load_signext = (i_funct3 == 3'b000) || (i_funct3 == 3'b001); // lb, lh
            end

            `RV_OPC_STORE:
            begin
                o_ctrl.wmem    = 1'b1;
                o_ctrl.aluimm  = 1'b1;
                o_ctrl.signext = 1'b1;
                ops.use_rs1    = 1'b1;
                ops.use_rs2    = 1'b1;
                o_ctrl.ls_b    = (i_funct3 == 3'b000);  // sb
                o_ctrl.ls_h    = (i_funct3 == 3'b001);  // sh
            end

            `RV_OPC_LUI:
            begin
                o_ctrl.wreg   = 1'b1;
                o_ctrl.aluimm = 1'b1;
                o_ctrl.aluc   = rv_ctrl_pkg::ALU_LUI;
            end

            `RV_OPC_AUIPC:
            begin
                o_ctrl.wreg    = 1'b1;
                o_ctrl.aluimm  = 1'b1;
                o_ctrl.signext = 1'b1;
                o_ctrl.auipc   = 1'b1;
            end

            `RV_OPC_JAL:
            begin
                o_ctrl.wreg = 1'b1;
                o_ctrl.jal  = 1'b1;                    // link pc+4 into rd
                o_branch    = rv_ctrl_pkg::BR_JAL;
            end

            `RV_OPC_JALR:
            begin
                o_ctrl.wreg    = 1'b1;
                o_ctrl.jal     = 1'b1;
                o_ctrl.jalr    = 1'b1;
                o_ctrl.signext = 1'b1;
                ops.use_rs1    = 1'b1;
                o_branch       = rv_ctrl_pkg::BR_JALR;
            end

            default: o_branch = rv_ctrl_pkg::BR_NONE;
        endcase
    end

endmodule

`default_nettype wire

/* branch_resolve.sv */
`default_nettype none

module branch_resolve (
    input  rv_ctrl_pkg::branch_kind_t i_branch,
    input  logic                      i_compare_lt, // rs1 < rs2, signedness set by decode
    input  logic                      i_compare_eq,
    output rv_ctrl_pkg::pc_sel_t      o_pcsrc,
    output logic                      o_flush
);

    logic taken;

    always_comb
    begin
        case (i_branch)
            rv_ctrl_pkg::BR_EQ: taken = i_compare_eq;
            rv_ctrl_pkg::BR_NE: taken = ~i_compare_eq;
            rv_ctrl_pkg::BR_LT: taken = i_compare_lt;
            rv_ctrl_pkg::BR_GE: taken = ~i_compare_lt;
            default:            taken = 1'b0;
        endcase
    end

    always_comb
    begin
        case (i_branch)
            rv_ctrl_pkg::BR_JAL:  o_pcsrc = rv_ctrl_pkg::PC_JAL;
            rv_ctrl_pkg::BR_JALR: o_pcsrc = rv_ctrl_pkg::PC_JALR;
            default:
            begin
                if (taken)
                    o_pcsrc = rv_ctrl_pkg::PC_BRANCH;
                else
                    o_pcsrc = rv_ctrl_pkg::PC_PC4;
            end
        endcase
    end

    // any redirect kills the instr fetched behind it
    assign o_flush = (o_pcsrc != rv_ctrl_pkg::PC_PC4);

endmodule

`default_nettype wire

/* forward_unit.sv */
`default_nettype none

module forward_unit (
    stage_wb_if.consumer         stages,
    operand_use_if.consumer      ops,
    output rv_ctrl_pkg::fwd_sel_t o_fwda,
    output rv_ctrl_pkg::fwd_sel_t o_fwdb
);

    logic exe_alu_wr; // exe writes an alu result to a real register
    logic mem_alu_wr;
    logic mem_ld_wr;  // mem holds load data headed for a real register

    assign exe_alu_wr = stages.exe_wreg && (stages.exe_rd != '0) && !stages.exe_mem2reg;
    assign mem_alu_wr = stages.mem_wreg && (stages.mem_rd != '0) && !stages.mem_mem2reg;
    assign mem_ld_wr  = stages.mem_wreg && (stages.mem_rd != '0) && stages.mem_mem2reg;

    // youngest producer wins
    function automatic rv_ctrl_pkg::fwd_sel_t pick_source(
        input rv_ctrl_pkg::reg_addr_t rs,
        input rv_ctrl_pkg::reg_addr_t exe_rd,
        input rv_ctrl_pkg::reg_addr_t mem_rd,
        input logic                   exe_alu,
        input logic                   mem_alu,
        input logic                   mem_ld
    );
        if (exe_alu && (exe_rd == rs))
            return rv_ctrl_pkg::FWD_EXE_ALU;
        else if (mem_alu && (mem_rd == rs))
            return rv_ctrl_pkg::FWD_MEM_ALU;
        else if (mem_ld && (mem_rd == rs))
            return rv_ctrl_pkg::FWD_MEM_LOAD;
        else
            return rv_ctrl_pkg::FWD_REGFILE;
    endfunction

    // use flags not consulted, a spurious forward is harmless
    assign o_fwda = pick_source(ops.rs1, stages.exe_rd, stages.mem_rd,
                                exe_alu_wr, mem_alu_wr, mem_ld_wr);
    assign o_fwdb = pick_source(ops.rs2, stages.exe_rd, stages.mem_rd,
                                exe_alu_wr, mem_alu_wr, mem_ld_wr);

endmodule

`default_nettype wire

/* load_use_stall.sv */
`default_nettype none

module load_use_stall (
    stage_wb_if.consumer       stages,
    operand_use_if.consumer    ops,
    input  rv_ctrl_pkg::ctrl_t i_ctrl,
    output rv_ctrl_pkg::ctrl_t o_ctrl,
    output logic               o_stall
);

    logic exe_load;
    logic hit_rs1;
    logic hit_rs2;

    // load data not ready until mem, so no forward path exists
    assign exe_load = stages.exe_wreg && stages.exe_mem2reg && (stages.exe_rd != '0);
    assign hit_rs1  = ops.use_rs1 && (stages.exe_rd == ops.rs1);
    assign hit_rs2  = ops.use_rs2 && (stages.exe_rd == ops.rs2);
    assign o_stall  = exe_load && (hit_rs1 || hit_rs2);

    always_comb
    begin
        o_ctrl      = i_ctrl;
        o_ctrl.wreg = i_ctrl.wreg & ~o_stall; // bubble: no side effects
        o_ctrl.wmem = i_ctrl.wmem & ~o_stall;
    end

endmodule

`default_nettype wire

/* control_unit.sv */
`default_nettype none

`include "rv_ctrl_settings.svh"

module control_unit (
    input  logic [`RV_OPC_W-1:0]    i_opcode,
    input  logic [`RV_FUNCT3_W-1:0] i_funct3,
    input  logic [`RV_FUNCT7_W-1:0] i_funct7,
    input  logic [`RV_REG_AW-1:0]   i_rs1,
    input  logic [`RV_REG_AW-1:0]   i_rs2,
    input  logic                    i_compare_lt,
    input  logic                    i_compare_eq,
    input  logic                    i_exe_wreg,
    input  logic                    i_exe_mem2reg,
    input  logic [`RV_REG_AW-1:0]   i_exe_rd,
    input  logic                    i_mem_wreg,
    input  logic                    i_mem_mem2reg,
    input  logic [`RV_REG_AW-1:0]   i_mem_rd,
    output logic                    o_not_stall,
    output logic                    o_flush,
    output rv_ctrl_pkg::pc_sel_t    o_pcsrc,
    output rv_ctrl_pkg::fwd_sel_t   o_fwda,
    output rv_ctrl_pkg::fwd_sel_t   o_fwdb,
    output rv_ctrl_pkg::alu_op_t    o_aluc,
    output logic                    o_wreg,
    output logic                    o_wmem,
    output logic                    o_mem2reg,
    output logic                    o_aluimm,
    output logic                    o_jal,
    output logic                    o_jalr,
    output logic                    o_signext,
    output logic                    o_auipc,
    output logic                    o_ls_b,
    output logic                    o_ls_h,
    output logic                    o_load_signext,
    output logic                    o_slt_instr,
    output logic                    o_compare_signed,
    output logic                    o_compare_imm
);

    rv_ctrl_pkg::ctrl_t        dec_ctrl;
    rv_ctrl_pkg::ctrl_t        ctrl;     // after stall gating
    rv_ctrl_pkg::branch_kind_t branch;
    logic                      stall;

    stage_wb_if    stages_if ();
    operand_use_if ops_if ();

    assign stages_if.exe_wreg    = i_exe_wreg;
    assign stages_if.exe_mem2reg = i_exe_mem2reg;
    assign stages_if.exe_rd      = i_exe_rd;
    assign stages_if.mem_wreg    = i_mem_wreg;
    assign stages_if.mem_mem2reg = i_mem_mem2reg;
    assign stages_if.mem_rd      = i_mem_rd;
    assign ops_if.rs1            = i_rs1;
    assign ops_if.rs2            = i_rs2;

    instr_decoder instr_decoder_inst (
        .i_opcode (i_opcode),
        .i_funct3 (i_funct3),
        .i_funct7 (i_funct7),
        .o_ctrl   (dec_ctrl),
        .o_branch (branch),
        .ops      (ops_if)
    );

    branch_resolve branch_resolve_inst (
        .i_branch     (branch),
        .i_compare_lt (i_compare_lt),
        .i_compare_eq (i_compare_eq),
        .o_pcsrc      (o_pcsrc),
        .o_flush      (o_flush)
    );

    forward_unit forward_unit_inst (
        .stages (stages_if),
        .ops    (ops_if),
        .o_fwda (o_fwda),
        .o_fwdb (o_fwdb)
    );

    load_use_stall load_use_stall_inst (
        .stages  (stages_if),
        .ops     (ops_if),
        .i_ctrl  (dec_ctrl),
        .o_ctrl  (ctrl),
        .o_stall (stall)
    );

    assign o_not_stall      = ~stall;
    assign o_aluc           = ctrl.aluc;
    assign o_wreg           = ctrl.wreg;
    assign o_wmem           = ctrl.wmem;
    assign o_mem2reg        = ctrl.mem2reg;
    assign o_aluimm         = ctrl.aluimm;
    assign o_jal            = ctrl.jal;
    assign o_jalr           = ctrl.jalr;
    assign o_signext        = ctrl.signext;
    assign o_auipc          = ctrl.auipc;
    assign o_ls_b           = ctrl.ls_b;
    assign o_ls_h           = ctrl.ls_h;
    assign o_load_signext   = ctrl.load_signext;
    assign o_slt_instr      = ctrl.slt_instr;
    assign o_compare_signed = ctrl.compare_signed;
    assign o_compare_imm    = ctrl.compare_imm;

endmodule

`default_nettype wire

/* tb_control_unit.sv */
`default_nettype none

`include "rv_ctrl_settings.svh"

module tb_control_unit;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [6:0]           opc;
        logic [2:0]           f3;
        logic [6:0]           f7;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [1:0]           cmp;   // {lt, eq}
        logic [6:0]           exe;   // {wreg, mem2reg, rd}
        logic [6:0]           mem;   // {wreg, mem2reg, rd}
        rv_ctrl_pkg::alu_op_t aluc;
        rv_ctrl_pkg::pc_sel_t pc;
        logic [15:0]          flags; // same bit order as got
    } row_t;

    localparam int N_GEN = 40;
    localparam rv_ctrl_pkg::pc_sel_t P4  = rv_ctrl_pkg::PC_PC4;
    localparam rv_ctrl_pkg::pc_sel_t BRA = rv_ctrl_pkg::PC_BRANCH;
    localparam rv_ctrl_pkg::pc_sel_t JMP = rv_ctrl_pkg::PC_JAL;
    localparam rv_ctrl_pkg::pc_sel_t JR  = rv_ctrl_pkg::PC_JALR;

    logic                  i_clk = 1'b0;
    logic                  i_reset = 1'b1;
    row_t                  cur;
    row_t                  rows[$];
    logic                  table_ready = 1'b0;
    int                    errors = 0;
    logic [15:0]           got;
    rv_ctrl_pkg::alu_op_t  aluc;
    rv_ctrl_pkg::pc_sel_t  pcsrc;
    rv_ctrl_pkg::fwd_sel_t fwda;
    rv_ctrl_pkg::fwd_sel_t fwdb;

    string flag_names [16] = '{"o_wreg", "o_wmem", "o_mem2reg", "o_aluimm", "o_jal", "o_jalr",
                               "o_signext", "o_auipc", "o_ls_b", "o_ls_h", "o_load_signext",
                               "o_slt_instr", "o_compare_signed", "o_compare_imm", "o_flush",
                               "o_not_stall"};

    always #50 i_clk = ~i_clk;

    control_unit control_unit_inst (
        .i_opcode         (cur.opc),
        .i_funct3         (cur.f3),
        .i_funct7         (cur.f7),
        .i_rs1            (cur.rs1),
        .i_rs2            (cur.rs2),
        .i_compare_lt     (cur.cmp[1]),
        .i_compare_eq     (cur.cmp[0]),
        .i_exe_wreg       (cur.exe[6]),
        .i_exe_mem2reg    (cur.exe[5]),
        .i_exe_rd         (cur.exe[4:0]),
        .i_mem_wreg       (cur.mem[6]),
        .i_mem_mem2reg    (cur.mem[5]),
        .i_mem_rd         (cur.mem[4:0]),
        .o_not_stall      (got[0]),
        .o_flush          (got[1]),
        .o_pcsrc          (pcsrc),
        .o_fwda           (fwda),
        .o_fwdb           (fwdb),
        .o_aluc           (aluc),
        .o_wreg           (got[15]),
        .o_wmem           (got[14]),
        .o_mem2reg        (got[13]),
        .o_aluimm         (got[12]),
        .o_jal            (got[11]),
        .o_jalr           (got[10]),
        .o_signext        (got[9]),
        .o_auipc          (got[8]),
        .o_ls_b           (got[7]),
        .o_ls_h           (got[6]),
        .o_load_signext   (got[5]),
        .o_slt_instr      (got[4]),
        .o_compare_signed (got[3]),
        .o_compare_imm    (got[2])
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // newest writer of a nonzero rd wins and loads forward only from mem
    function automatic rv_ctrl_pkg::fwd_sel_t expect_fwd(input logic [4:0] rs,
                                                         input logic [6:0] exe,
                                                         input logic [6:0] mem);
        if (exe[6] && !exe[5] && (exe[4:0] != 5'd0) && (exe[4:0] == rs))
            return rv_ctrl_pkg::FWD_EXE_ALU;
        if (mem[6] && (mem[4:0] != 5'd0) && (mem[4:0] == rs))
            return mem[5] ? rv_ctrl_pkg::FWD_MEM_LOAD : rv_ctrl_pkg::FWD_MEM_ALU;
        return rv_ctrl_pkg::FWD_REGFILE;
    endfunction

    task automatic stop_on_error();
        errors++;
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_alu_op(input string name, input rv_ctrl_pkg::alu_op_t got_v,
                                input rv_ctrl_pkg::alu_op_t exp_v);
        if (got_v !== exp_v)
        begin
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got_v, exp_v);
            stop_on_error();
        end
    endtask

    task automatic check_fwd(input string name, input rv_ctrl_pkg::fwd_sel_t got_v,
                             input rv_ctrl_pkg::fwd_sel_t exp_v);
        if (got_v !== exp_v)
        begin
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got_v, exp_v);
            stop_on_error();
        end
    endtask

    task automatic check_pc(input string name, input rv_ctrl_pkg::pc_sel_t got_v,
                            input rv_ctrl_pkg::pc_sel_t exp_v);
        if (got_v !== exp_v)
        begin
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got_v, exp_v);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got_v, input logic exp_v);
        if (got_v !== exp_v)
        begin
            $display("FAIL t=%0t %s got %b expected %b", $time, name, got_v, exp_v);
            stop_on_error();
        end
    endtask

    task automatic verify_row(input row_t r);
        check_alu_op("o_aluc", aluc, r.aluc);
        check_pc("o_pcsrc", pcsrc, r.pc);
        check_fwd("o_fwda", fwda, expect_fwd(r.rs1, r.exe, r.mem));
        check_fwd("o_fwdb", fwdb, expect_fwd(r.rs2, r.exe, r.mem));
        for (int b = 0; b < 16; b++)
            check_bit(flag_names[b], got[15 - b], r.flags[15 - b]);
    endtask

    task automatic add_row(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
                           input logic [1:0] cmp, input rv_ctrl_pkg::alu_op_t op,
                           input rv_ctrl_pkg::pc_sel_t pc, input logic [15:0] flags);
        row_t r;
        r = '{opc, f3, f7, 5'd0, 5'd0, cmp, 7'd0, 7'd0, op, pc, flags};
        rows.push_back(r);
    endtask

    // puts a producer in exe behind the last row
    task automatic set_hazard(input logic [6:0] exe, input logic [4:0] rs1,
                              input logic [4:0] rs2);
        row_t r;
        r     = rows.pop_back();
        r.exe = exe;
        r.rs1 = rs1;
        r.rs2 = rs2;
        rows.push_back(r);
    endtask

    // flag nibbles in hex from the top {wreg wmem mem2reg aluimm} {jal jalr signext auipc}
    // {ls_b ls_h load_signext slt} {compare_signed compare_imm flush not_stall}
    task automatic build_table();
        row_t        r;
        logic [31:0] seed;
        logic        stall;
        add_row(`RV_OPC_R, 3'd0, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'h8201);
        add_row(`RV_OPC_R, 3'd1, 7'h00, 2'b00, rv_ctrl_pkg::ALU_SLL, P4, 16'h8201);
        add_row(`RV_OPC_R, 3'd2, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'h8219);
        add_row(`RV_OPC_R, 3'd3, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'h8211);
        add_row(`RV_OPC_R, 3'd4, 7'h00, 2'b00, rv_ctrl_pkg::ALU_XOR, P4, 16'h8201);
        add_row(`RV_OPC_R, 3'd5, 7'h00, 2'b00, rv_ctrl_pkg::ALU_SRL, P4, 16'h8201);
        add_row(`RV_OPC_R, 3'd6, 7'h00, 2'b00, rv_ctrl_pkg::ALU_OR, P4, 16'h8201);
        add_row(`RV_OPC_R, 3'd7, 7'h00, 2'b00, rv_ctrl_pkg::ALU_AND, P4, 16'h8201);
        add_row(`RV_OPC_R, 3'd0, 7'h20, 2'b00, rv_ctrl_pkg::ALU_SUB, P4, 16'h8201);
        add_row(`RV_OPC_R, 3'd5, 7'h20, 2'b00, rv_ctrl_pkg::ALU_SRA, P4, 16'h8201);
        add_row(`RV_OPC_R, 3'd0, 7'h01, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'h8201); // old mul
        add_row(`RV_OPC_I, 3'd0, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'h9201);
        add_row(`RV_OPC_I, 3'd1, 7'h00, 2'b00, rv_ctrl_pkg::ALU_SLL, P4, 16'h9001);
        add_row(`RV_OPC_I, 3'd2, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'h921D);
        add_row(`RV_OPC_I, 3'd3, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'h9215);
        add_row(`RV_OPC_I, 3'd4, 7'h00, 2'b00, rv_ctrl_pkg::ALU_XOR, P4, 16'h9201);
        add_row(`RV_OPC_I, 3'd5, 7'h00, 2'b00, rv_ctrl_pkg::ALU_SRL, P4, 16'h9001);
        add_row(`RV_OPC_I, 3'd5, 7'h20, 2'b00, rv_ctrl_pkg::ALU_SRA, P4, 16'h9001);
        add_row(`RV_OPC_I, 3'd6, 7'h00, 2'b00, rv_ctrl_pkg::ALU_OR, P4, 16'h9201);
        add_row(`RV_OPC_I, 3'd7, 7'h00, 2'b00, rv_ctrl_pkg::ALU_AND, P4, 16'h9201);
        add_row(`RV_OPC_LOAD, 3'd0, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'hB2A1);
        add_row(`RV_OPC_LOAD, 3'd1, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'hB261);
        add_row(`RV_OPC_LOAD, 3'd2, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'hB201);
        add_row(`RV_OPC_LOAD, 3'd4, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'hB281);
        add_row(`RV_OPC_LOAD, 3'd5, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'hB241);
        add_row(`RV_OPC_STORE, 3'd0, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'h5281);
        add_row(`RV_OPC_STORE, 3'd1, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'h5241);
        add_row(`RV_OPC_STORE, 3'd2, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'h5201);
        add_row(`RV_OPC_LUI, 3'd0, 7'h00, 2'b00, rv_ctrl_pkg::ALU_LUI, P4, 16'h9001);
        add_row(`RV_OPC_AUIPC, 3'd0, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'h9301);
        add_row(`RV_OPC_B, 3'd0, 7'h00, 2'b01, rv_ctrl_pkg::ALU_ADD, BRA, 16'h020B);
        add_row(`RV_OPC_B, 3'd0, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'h0209);
        add_row(`RV_OPC_B, 3'd1, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, BRA, 16'h020B);
        add_row(`RV_OPC_B, 3'd1, 7'h00, 2'b01, rv_ctrl_pkg::ALU_ADD, P4, 16'h0209);
        add_row(`RV_OPC_B, 3'd4, 7'h00, 2'b10, rv_ctrl_pkg::ALU_ADD, BRA, 16'h020B);
        add_row(`RV_OPC_B, 3'd6, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'h0201);
        add_row(`RV_OPC_B, 3'd5, 7'h00, 2'b10, rv_ctrl_pkg::ALU_ADD, P4, 16'h0209);
        add_row(`RV_OPC_B, 3'd7, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, BRA, 16'h0203);
        add_row(`RV_OPC_JAL, 3'd0, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, JMP, 16'h8803);
        add_row(`RV_OPC_JALR, 3'd0, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, JR, 16'h8E03);
        add_row(7'b1111111, 3'd0, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'h0001);
        add_row(`RV_OPC_R, 3'd0, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'h0200);
        set_hazard({2'b11, 5'd6}, 5'd5, 5'd6);
        add_row(`RV_OPC_STORE, 3'd2, 7'h00, 2'b00, rv_ctrl_pkg::ALU_ADD, P4, 16'h1200);
        set_hazard({2'b11, 5'd3}, 5'd1, 5'd3);
        add_row(`RV_OPC_LUI, 3'd0, 7'h00, 2'b00, rv_ctrl_pkg::ALU_LUI, P4, 16'h9001);
        set_hazard({2'b11, 5'd7}, 5'd7, 5'd7);                  // neither source used by lui
        seed = 32'd79;
        for (int g = 0; g < N_GEN; g++)
        begin
            seed    = xorshift(seed);
            r       = '0;
            r.opc   = `RV_OPC_R;                   // add reads both sources
            r.rs1   = {3'b000, seed[1:0]};         // small indices so rd matches often
            r.rs2   = {3'b000, seed[3:2]};
            r.exe   = {seed[8:7], 3'b000, seed[5:4]};
            r.mem   = {seed[10:9], 3'b000, seed[12:11]};
            stall   = r.exe[6] && r.exe[5] && (r.exe[4:0] != 5'd0) &&
                      ((r.exe[4:0] == r.rs1) || (r.exe[4:0] == r.rs2));
            r.aluc  = rv_ctrl_pkg::ALU_ADD;
            r.pc    = rv_ctrl_pkg::PC_PC4;
            r.flags = stall ? 16'h0200 : 16'h8201;
            rows.push_back(r);
        end
    endtask

    initial
    begin
        repeat (8) @(posedge i_clk);
        #2ns i_reset = 1'b0;
    end

    initial
    begin
        cur = '0;
        build_table();
        table_ready = 1'b1;
        wait (!i_reset);                             // stimulus starts once reset is released
        for (int k = 0; k < rows.size(); k++)
        begin
            @(posedge i_clk);
            #2ns cur = rows[k];
            #90ns verify_row(rows[k]);               // sample late in the cycle
        end
        @(posedge i_clk);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        wait (table_ready);
        #((rows.size() + 20) * 100);
        $display("timeout: the stimulus loop did not finish in time");
        stop_on_error();
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
rv_ctrl_pkg.sv
rv_ctrl_if.sv
instr_decoder.sv
branch_resolve.sv
forward_unit.sv
load_use_stall.sv
control_unit.sv
tb_control_unit.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps -f compile.f \
    --top-module tb_control_unit -o tb_control_unit_sim &&
./obj_dir/tb_control_unit_sim | tee /dev/stderr | grep -q "STATUS: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
